// File: vlog.f
+incdir+.
soc_pkg.sv
soc_bus_if.sv
bus_access.sv
system_bus_map.sv
bram.sv
far_devices.sv
soc_top.sv
tb_soc_asserts.sv
tb_soc_checker.sv
tb_soc.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - soc_bus_if.sv
      - bus_access.sv
      - system_bus_map.sv
      - bram.sv
      - far_devices.sv
      - soc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_soc_asserts.sv
      - tb_soc_checker.sv
      - tb_soc.sv

// File: tb_soc.sv
//==========================================================================
// SoC bus testbench: clock, reset, xorshift stimulus, DUT, checker, timeout
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc;

	localparam int RAM_FILL        = 64;
	localparam int SINGLE_ACCESSES = 100;
	localparam int FETCHES         = 32;
	localparam int MIXED_PER_PORT  = 40;
	localparam int PLANNED = RAM_FILL + SINGLE_ACCESSES + FETCHES + 3 * MIXED_PER_PORT + 11;
	localparam int CYCLE_LIMIT = 20 * PLANNED + 200;

	localparam logic [31:0] LED_ADDRESS     = {`SOC_REGION_BRIDGE, `SOC_DEV_LED, 24'h0};
	localparam logic [31:0] COUNT_ADDRESS   =
		{`SOC_REGION_BRIDGE, `SOC_DEV_TIMER, 20'h0, `SOC_TIMER_OFS_COUNT};
	localparam logic [31:0] COMPARE_ADDRESS =
		{`SOC_REGION_BRIDGE, `SOC_DEV_TIMER, 20'h0, `SOC_TIMER_OFS_COMPARE};

	logic                   i_clock;
	logic                   i_reset;
	logic                   i_pa_request;
	logic [`SOC_ADDR_W-1:0] i_pa_address;
	logic [`SOC_DATA_W-1:0] o_pa_rdata;
	logic                   o_pa_ready;
	logic                   i_pb_request;
	logic                   i_pb_rw;
	logic [`SOC_ADDR_W-1:0] i_pb_address;
	logic [`SOC_DATA_W-1:0] i_pb_wdata;
	logic [`SOC_DATA_W-1:0] o_pb_rdata;
	logic                   o_pb_ready;
	logic                   i_pc_request;
	logic                   i_pc_rw;
	logic [`SOC_ADDR_W-1:0] i_pc_address;
	logic [`SOC_DATA_W-1:0] i_pc_wdata;
	logic [`SOC_DATA_W-1:0] o_pc_rdata;
	logic                   o_pc_ready;
	logic [`SOC_LED_W-1:0]  o_ledr;
	logic                   o_timer_interrupt;

	int          value_errors;
	int          protocol_errors;
	int          cycles = 0;
	logic [31:0] rng_state = 32'd28592;

	// Stimulus of the concurrent phase, drawn before the ports start
	logic [31:0] mixed_address [3][MIXED_PER_PORT];
	logic        mixed_rw      [3][MIXED_PER_PORT];
	logic [31:0] mixed_wdata   [3][MIXED_PER_PORT];
	int          mixed_gap     [3][MIXED_PER_PORT];

	soc_top dut0 (.*);

	tb_soc_checker checker0 (
		.*,
		.o_value_errors    (value_errors),
		.o_protocol_errors (protocol_errors)
	);

	always #2 i_clock = ~i_clock;

	function automatic logic [31:0] xorshift();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// RAM address with random bits above and below the word index
	function automatic logic [31:0] ram_address(input logic [8:0] index, input logic [31:0] noise);
		return {`SOC_REGION_RAM, noise[27:11], index, noise[1:0]};
	endfunction

	function automatic logic port_ready(input int port);
		case (port)
			0:       return o_pa_ready;
			1:       return o_pb_ready;
			default: return o_pc_ready;
		endcase
	endfunction

	//==========================================================================
	// One access on port 0 (A), 1 (B) or 2 (C), held until that port's ready
	//==========================================================================
	task automatic run_access(input int port, input logic rw, input logic [31:0] address,
			input logic [31:0] wdata);
		@(posedge i_clock);
		case (port)
			0: begin
				i_pa_request <= 1'b1;
				i_pa_address <= address;
			end
			1: begin
				i_pb_request <= 1'b1;
				i_pb_rw <= rw;
				i_pb_address <= address;
				i_pb_wdata <= wdata;
			end
			default: begin
				i_pc_request <= 1'b1;
				i_pc_rw <= rw;
				i_pc_address <= address;
				i_pc_wdata <= wdata;
			end
		endcase
		do
			@(posedge i_clock);
		while (!port_ready(port));
		case (port)
			0:       i_pa_request <= 1'b0;
			1:       i_pb_request <= 1'b0;
			default: i_pc_request <= 1'b0;
		endcase
	endtask

	task automatic port_stream(input int port);
		for (int i = 0; i < MIXED_PER_PORT; i++) begin
			repeat (mixed_gap[port][i]) @(posedge i_clock);
			run_access(port, mixed_rw[port][i], mixed_address[port][i], mixed_wdata[port][i]);
		end
	endtask

	task automatic print_counts();
		$display("Errors: %0d value, %0d protocol, %0d assertion",
			value_errors, protocol_errors, dut0.bus_access0.asserts0.failures);
	endtask

	always @(posedge i_clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still busy after %0d cycles, a port never got ready",
				CYCLE_LIMIT);
			print_counts();
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] draw;
		logic [31:0] noise;
		logic [31:0] data;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_pa_request = 1'b0;
		i_pa_address = '0;
		i_pb_request = 1'b0;
		i_pb_rw = 1'b0;
		i_pb_address = '0;
		i_pb_wdata = '0;
		i_pc_request = 1'b0;
		i_pc_rw = 1'b0;
		i_pc_address = '0;
		i_pc_wdata = '0;
		repeat (5) @(posedge i_clock);
		i_reset <= 1'b0;

		// Fill the low words from B and C in turn
		for (int i = 0; i < RAM_FILL; i++) begin
			noise = xorshift();
			data = xorshift();
			run_access(1 + i % 2, 1'b1, ram_address(9'(i), noise), data);
		end

		// Single-port random reads and writes with aliased addresses
		for (int i = 0; i < SINGLE_ACCESSES; i++) begin
			draw = xorshift();
			noise = xorshift();
			data = xorshift();
			run_access(1 + draw[0], draw[1], ram_address({3'b0, draw[7:2]}, noise), data);
		end

		// Instruction fetches
		for (int i = 0; i < FETCHES; i++) begin
			draw = xorshift();
			noise = xorshift();
			run_access(0, 1'b0, ram_address({3'b0, draw[5:0]}, noise), '0);
		end

		for (int p = 0; p < 3; p++) begin
			for (int i = 0; i < MIXED_PER_PORT; i++) begin
				draw = xorshift();
				mixed_address[p][i] = ram_address({3'b0, draw[5:0]}, xorshift());
				mixed_rw[p][i] = (p != 0) && draw[6];
				mixed_wdata[p][i] = xorshift();
				mixed_gap[p][i] = draw[8:7];
			end
		end
		fork
			port_stream(0);
			port_stream(1);
			port_stream(2);
		join

		// LEDs, unmapped region and unknown far device
		run_access(1, 1'b1, LED_ADDRESS, xorshift());
		run_access(2, 1'b0, LED_ADDRESS, '0);
		run_access(1, 1'b0, {4'h3, 28'h0000010}, '0);
		run_access(2, 1'b0, {`SOC_REGION_BRIDGE, 4'h2, 24'h0}, '0);

		// Timer
		run_access(1, 1'b0, COUNT_ADDRESS, '0);
		run_access(1, 1'b0, COUNT_ADDRESS, '0);
		run_access(1, 1'b1, COUNT_ADDRESS, 32'h0);
		run_access(1, 1'b1, COMPARE_ADDRESS, 32'hFFFF_0000);
		repeat (20) @(posedge i_clock);
		run_access(2, 1'b0, COMPARE_ADDRESS, '0);
		run_access(1, 1'b1, COMPARE_ADDRESS, 32'h0);
		repeat (3) @(posedge i_clock);
		run_access(2, 1'b0, COMPARE_ADDRESS, '0);

		repeat (4) @(posedge i_clock);
		print_counts();
		if (value_errors + protocol_errors + dut0.bus_access0.asserts0.failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: tb_soc_checker.sv
//==========================================================================
// Port monitor with RAM, LED and timer models, counts value and protocol errors
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_checker (
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_pa_request,
	input  logic [`SOC_ADDR_W-1:0] i_pa_address,
	input  logic [`SOC_DATA_W-1:0] o_pa_rdata,
	input  logic                   o_pa_ready,
	input  logic                   i_pb_request,
	input  logic                   i_pb_rw,
	input  logic [`SOC_ADDR_W-1:0] i_pb_address,
	input  logic [`SOC_DATA_W-1:0] i_pb_wdata,
	input  logic [`SOC_DATA_W-1:0] o_pb_rdata,
	input  logic                   o_pb_ready,
	input  logic                   i_pc_request,
	input  logic                   i_pc_rw,
	input  logic [`SOC_ADDR_W-1:0] i_pc_address,
	input  logic [`SOC_DATA_W-1:0] i_pc_wdata,
	input  logic [`SOC_DATA_W-1:0] o_pc_rdata,
	input  logic                   o_pc_ready,
	input  logic [`SOC_LED_W-1:0]  o_ledr,
	input  logic                   o_timer_interrupt,
	output int                     o_value_errors,
	output int                     o_protocol_errors
);
	import soc_pkg::*;

	logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];
	logic                   written [`SOC_RAM_WORDS];
	logic [`SOC_LED_W-1:0]  led_model;
	logic [`SOC_DATA_W-1:0] compare_model;
	logic [`SOC_DATA_W-1:0] count_floor;
	logic                   count_zero;
	logic                   irq_high_next;
	logic                   irq_low_hold;
	logic                   reset_seen;

	initial begin
		o_value_errors = 0;
		o_protocol_errors = 0;
		reset_seen = 1'b0;
	end

	function automatic region_t region_of(input logic [`SOC_ADDR_W-1:0] address);
		case (address[31:28])
			`SOC_REGION_RAM:    return REGION_RAM;
			`SOC_REGION_BRIDGE: return REGION_BRIDGE;
			default:            return REGION_NONE;
		endcase
	endfunction

	function automatic far_device_t device_of(input logic [`SOC_ADDR_W-1:0] address);
		case (address[27:24])
			`SOC_DEV_LED:   return DEV_LED;
			`SOC_DEV_TIMER: return DEV_TIMER;
			default:        return DEV_NONE;
		endcase
	endfunction

	task automatic value_error(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAILED %s: expected %h, got %h", name, expected, actual);
		o_value_errors++;
	endtask

	task automatic protocol_error(input string what);
		$display("Protocol error at %0t: %s", $time, what);
		o_protocol_errors++;
	endtask

	//==========================================================================
	// One completed access, applied to the model in completion order
	//==========================================================================
	task automatic check_access(input string name, input logic rw,
			input logic [31:0] address, input logic [31:0] wdata, input logic [31:0] rdata);
		logic [`SOC_DATA_W-1:0] expected;
		logic                   compare_data;
		logic [8:0]             index;
		expected = '0;
		compare_data = !rw;
		index = address[10:2];
		case (region_of(address))
			REGION_RAM: begin
				if (rw) begin
					mem[index] = wdata;
					written[index] = 1'b1;
				end else begin
					expected = mem[index];
					compare_data = written[index];
				end
			end
			REGION_BRIDGE: begin
				case (device_of(address))
					DEV_LED: begin
						if (rw)
							led_model = wdata[`SOC_LED_W-1:0];
					end
					DEV_TIMER: begin
						if (address[3:0] == `SOC_TIMER_OFS_COUNT) begin
							if (rw) begin
								count_floor = wdata;
								count_zero = (wdata == '0);
								irq_low_hold = 1'b0;
							end else begin
								// Free-running, so only the ordering is known
								if (rdata <= count_floor) begin
									$display("FAILED %s: expected above %h, got %h",
										name, count_floor, rdata);
									o_value_errors++;
								end
								count_floor = rdata;
								compare_data = 1'b0;
							end
						end else if (address[3:0] == `SOC_TIMER_OFS_COMPARE) begin
							if (rw) begin
								compare_model = wdata;
								irq_high_next = (wdata == '0);
								irq_low_hold = count_zero && wdata[31];
							end else
								expected = compare_model;
						end
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		if (compare_data && rdata !== expected)
			value_error(name, expected, rdata);
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			if (reset_seen && (o_pa_ready || o_pb_ready || o_pc_ready ||
					o_ledr !== '0 || o_timer_interrupt !== 1'b0))
				protocol_error("outputs not cleared during reset");
			reset_seen = 1'b1;
			foreach (written[i])
				written[i] = 1'b0;
			led_model = '0;
			compare_model = '1;
			count_floor = '0;
			count_zero = 1'b0;
			irq_high_next = 1'b0;
			irq_low_hold = 1'b0;
		end else begin
			if (irq_high_next && o_timer_interrupt !== 1'b1)
				value_error("o_timer_interrupt", 32'h1, {31'h0, o_timer_interrupt});
			irq_high_next = 1'b0;
			if (irq_low_hold && o_timer_interrupt !== 1'b0)
				value_error("o_timer_interrupt", 32'h0, {31'h0, o_timer_interrupt});
			if ($countones({o_pa_ready, o_pb_ready, o_pc_ready}) > 1)
				protocol_error("more than one port ready in the same cycle");
			if ((o_pa_ready && !i_pa_request) || (o_pb_ready && !i_pb_request) ||
					(o_pc_ready && !i_pc_request))
				protocol_error("ready on a port that is not requesting");
			if (o_pa_ready)
				check_access("o_pa_rdata", 1'b0, i_pa_address, '0, o_pa_rdata);
			if (o_pb_ready)
				check_access("o_pb_rdata", i_pb_rw, i_pb_address, i_pb_wdata, o_pb_rdata);
			if (o_pc_ready)
				check_access("o_pc_rdata", i_pc_rw, i_pc_address, i_pc_wdata, o_pc_rdata);
			if (o_ledr !== led_model)
				value_error("o_ledr", led_model, o_ledr);
		end
	end

endmodule

// File: tb_soc_asserts.sv
//==========================================================================
// Handshake assertions on the arbiter and their bind into bus_access
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_asserts (
	input logic                   i_clock,
	input logic                   i_reset,
	input soc_pkg::arb_state_t    i_state,
	input logic                   i_pa_request,
	input logic                   i_pb_request,
	input logic                   i_pc_request,
	input logic                   i_pa_ready,
	input logic                   i_pb_ready,
	input logic                   i_pc_ready,
	input logic                   i_bus_request,
	input logic [`SOC_ADDR_W-1:0] i_bus_address
);

	int   failures = 0;
	logic any_ready;

	assign any_ready = i_pa_ready || i_pb_ready || i_pc_ready;

	a_single_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0({i_pa_ready, i_pb_ready, i_pc_ready}))
	else begin
		failures++;
		$error("more than one port ready in the same cycle");
	end

	// Ready only while the port still requests
	a_ready_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		(!i_pa_ready || i_pa_request) &&
		(!i_pb_ready || i_pb_request) &&
		(!i_pc_ready || i_pc_request))
	else begin
		failures++;
		$error("port ready without its request");
	end

	// Request, address and grant held until ready
	a_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !any_ready |=>
			i_bus_request && $stable(i_bus_address) && $stable(i_state))
	else begin
		failures++;
		$error("system bus request dropped or changed before ready");
	end

endmodule

bind bus_access tb_soc_asserts asserts0 (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_state       (state),
	.i_pa_request  (i_pa_request),
	.i_pb_request  (i_pb_request),
	.i_pc_request  (i_pc_request),
	.i_pa_ready    (o_pa_ready),
	.i_pb_ready    (o_pb_ready),
	.i_pc_ready    (o_pc_ready),
	.i_bus_request (bus_request),
	.i_bus_address (bus_address)
);

// File: soc_top.sv
//==========================================================================
// SoC bus top: arbiter, address map, block RAM and far devices
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
	input  logic                   i_clock,
	input  logic                   i_reset,

	// Port A, instruction fetch
	input  logic                   i_pa_request,
	input  logic [`SOC_ADDR_W-1:0] i_pa_address,
	output logic [`SOC_DATA_W-1:0] o_pa_rdata,
	output logic                   o_pa_ready,

	// Port B, data
	input  logic                   i_pb_request,
	input  logic                   i_pb_rw,
	input  logic [`SOC_ADDR_W-1:0] i_pb_address,
	input  logic [`SOC_DATA_W-1:0] i_pb_wdata,
	output logic [`SOC_DATA_W-1:0] o_pb_rdata,
	output logic                   o_pb_ready,

	// Port C, external DMA traffic
	input  logic                   i_pc_request,
	input  logic                   i_pc_rw,
	input  logic [`SOC_ADDR_W-1:0] i_pc_address,
	input  logic [`SOC_DATA_W-1:0] i_pc_wdata,
	output logic [`SOC_DATA_W-1:0] o_pc_rdata,
	output logic                   o_pc_ready,

	output logic [`SOC_LED_W-1:0]  o_ledr,
	output logic                   o_timer_interrupt
);

	soc_bus_if sys_bus ();
	soc_bus_if ram_bus ();
	soc_bus_if far_bus ();

	bus_access bus_access0 (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_pa_request (i_pa_request),
		.i_pa_address (i_pa_address),
		.o_pa_rdata   (o_pa_rdata),
		.o_pa_ready   (o_pa_ready),
		.i_pb_request (i_pb_request),
		.i_pb_rw      (i_pb_rw),
		.i_pb_address (i_pb_address),
		.i_pb_wdata   (i_pb_wdata),
		.o_pb_rdata   (o_pb_rdata),
		.o_pb_ready   (o_pb_ready),
		.i_pc_request (i_pc_request),
		.i_pc_rw      (i_pc_rw),
		.i_pc_address (i_pc_address),
		.i_pc_wdata   (i_pc_wdata),
		.o_pc_rdata   (o_pc_rdata),
		.o_pc_ready   (o_pc_ready),
		.bus          (sys_bus.master)
	);

	system_bus_map system_bus_map0 (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.sys_bus (sys_bus.slave),
		.ram_bus (ram_bus.master),
		.far_bus (far_bus.master)
	);

	bram ram0 (
		.i_clock (i_clock),
		.ram_bus (ram_bus.slave)
	);

	far_devices far_devices0 (
		.i_clock           (i_clock),
		.i_reset           (i_reset),
		.far_bus           (far_bus.slave),
		.o_ledr            (o_ledr),
		.o_timer_interrupt (o_timer_interrupt)
	);

endmodule

// File: far_devices.sv
//==========================================================================
// Far bus devices: red LED register and compare timer
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module far_devices (
	input  logic                 i_clock,
	input  logic                 i_reset,
	soc_bus_if.slave             far_bus,
	output logic [`SOC_LED_W-1:0] o_ledr,
	output logic                 o_timer_interrupt
);
	import soc_pkg::*;

	far_device_t            device;
	logic [3:0]             offset;
	logic                   accept;
	logic                   write;
	logic                   ready;
	logic [`SOC_DATA_W-1:0] rdata;
	logic [`SOC_DATA_W-1:0] counter;
	logic [`SOC_DATA_W-1:0] compare;

	always_comb begin
		case (far_bus.address[27:24])
			`SOC_DEV_LED:   device = DEV_LED;
			`SOC_DEV_TIMER: device = DEV_TIMER;
			default:        device = DEV_NONE;
		endcase
	end

	assign offset = far_bus.address[3:0];
	assign accept = far_bus.request && !ready;
	assign write  = accept && far_bus.rw;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			ready <= 1'b0;
		else
			ready <= accept;
	end

	// Only timer registers read back, everything else is zero
	always_ff @(posedge i_clock) begin
		if (accept) begin
			rdata <= '0;
			if (device == DEV_TIMER && offset == `SOC_TIMER_OFS_COUNT)
				rdata <= counter;
			else if (device == DEV_TIMER && offset == `SOC_TIMER_OFS_COMPARE)
				rdata <= compare;
		end
	end

	assign far_bus.ready = ready;
	assign far_bus.rdata = rdata;

	//==========================================================================
	// LEDs
	//==========================================================================
	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_ledr <= '0;
		else if (write && device == DEV_LED)
			o_ledr <= far_bus.wdata[`SOC_LED_W-1:0];
	end

	//==========================================================================
	// Timer
	//==========================================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			counter <= '0;
			compare <= '1;
			o_timer_interrupt <= 1'b0;
		end else begin
			if (write && device == DEV_TIMER && offset == `SOC_TIMER_OFS_COUNT)
				counter <= far_bus.wdata;
			else
				counter <= counter + 1'b1;
			if (write && device == DEV_TIMER && offset == `SOC_TIMER_OFS_COMPARE)
				compare <= far_bus.wdata;
			// Level, stays up until compare moves past the counter
			o_timer_interrupt <= (counter >= compare);
		end
	end

endmodule

// File: bram.sv
//==========================================================================
// Word-addressed block RAM, one cycle to ready
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module bram (
	input  logic     i_clock,
	soc_bus_if.slave ram_bus
);
	localparam int INDEX_W = $clog2(`SOC_RAM_WORDS);

	logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];
	logic [INDEX_W-1:0]     index;
	logic                   accept;
	logic                   ready;
	logic [`SOC_DATA_W-1:0] rdata;

	// Word index, upper address bits alias
	assign index  = ram_bus.address[INDEX_W+1:2];
	assign accept = ram_bus.request && !ready;

	// read-before-write, so a write cycle returns the old word
	always_ff @(posedge i_clock) begin
		ready <= accept;
		if (accept) begin
			rdata <= mem[index];
			if (ram_bus.rw)
				mem[index] <= ram_bus.wdata;
		end
	end

	assign ram_bus.ready = ready;
	assign ram_bus.rdata = rdata;

endmodule

// File: system_bus_map.sv
//==========================================================================
// System address decode, bridge register stage and response muxing
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module system_bus_map (
	input  logic      i_clock,
	input  logic      i_reset,
	soc_bus_if.slave  sys_bus,
	soc_bus_if.master ram_bus,
	soc_bus_if.master far_bus
);
	import soc_pkg::*;

	region_t                region;
	logic                   bridge_start;
	logic                   far_request;
	logic                   far_rw;
	logic [`SOC_ADDR_W-1:0] far_address;
	logic [`SOC_DATA_W-1:0] far_wdata;
	logic                   none_ready;

	// Region from the top nibble
	always_comb begin
		case (sys_bus.address[31:28])
			`SOC_REGION_RAM:    region = REGION_RAM;
			`SOC_REGION_BRIDGE: region = REGION_BRIDGE;
			default:            region = REGION_NONE;
		endcase
	end

	// RAM sees the system bus directly
	assign ram_bus.request = sys_bus.request && (region == REGION_RAM);
	assign ram_bus.rw      = sys_bus.rw;
	assign ram_bus.address = sys_bus.address;
	assign ram_bus.wdata   = sys_bus.wdata;

	//==========================================================================
	// Bridge stage
	//==========================================================================
	assign bridge_start = sys_bus.request && (region == REGION_BRIDGE) && !far_request;

	// Held until far ready, then idle while the arbiter releases
	always_ff @(posedge i_clock) begin
		if (i_reset)
			far_request <= 1'b0;
		else if (far_request)
			far_request <= !far_bus.ready;
		else if (bridge_start)
			far_request <= 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (bridge_start) begin
			far_rw <= sys_bus.rw;
			far_address <= {4'h0, sys_bus.address[27:0]};
			far_wdata <= sys_bus.wdata;
		end
	end

	assign far_bus.request = far_request;
	assign far_bus.rw      = far_rw;
	assign far_bus.address = far_address;
	assign far_bus.wdata   = far_wdata;

	// Unmapped regions still complete, with zero data
	always_ff @(posedge i_clock) begin
		if (i_reset)
			none_ready <= 1'b0;
		else
			none_ready <= sys_bus.request && (region == REGION_NONE) && !none_ready;
	end

	always_comb begin
		case (region)
			REGION_RAM: begin
				sys_bus.rdata = ram_bus.rdata;
				sys_bus.ready = ram_bus.ready;
			end
			REGION_BRIDGE: begin
				sys_bus.rdata = far_bus.rdata;
				sys_bus.ready = far_bus.ready;
			end
			default: begin
				sys_bus.rdata = '0;
				sys_bus.ready = none_ready;
			end
		endcase
	end

endmodule

// File: bus_access.sv
//==========================================================================
// Fixed-priority arbiter of ports A, B and C onto the registered system bus
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

module bus_access (
	input  logic                   i_clock,
	input  logic                   i_reset,

	// Port A, instruction fetch, read only
	input  logic                   i_pa_request,
	input  logic [`SOC_ADDR_W-1:0] i_pa_address,
	output logic [`SOC_DATA_W-1:0] o_pa_rdata,
	output logic                   o_pa_ready,

	// Port B, data
	input  logic                   i_pb_request,
	input  logic                   i_pb_rw,
	input  logic [`SOC_ADDR_W-1:0] i_pb_address,
	input  logic [`SOC_DATA_W-1:0] i_pb_wdata,
	output logic [`SOC_DATA_W-1:0] o_pb_rdata,
	output logic                   o_pb_ready,

	// Port C, DMA
	input  logic                   i_pc_request,
	input  logic                   i_pc_rw,
	input  logic [`SOC_ADDR_W-1:0] i_pc_address,
	input  logic [`SOC_DATA_W-1:0] i_pc_wdata,
	output logic [`SOC_DATA_W-1:0] o_pc_rdata,
	output logic                   o_pc_ready,

	soc_bus_if.master              bus
);
	import soc_pkg::*;

	arb_state_t             state;
	arb_state_t             grant;
	logic                   bus_request;
	logic                   bus_rw;
	logic [`SOC_ADDR_W-1:0] bus_address;
	logic [`SOC_DATA_W-1:0] bus_wdata;

	// Highest priority waiting port, A first
	always_comb begin
		grant = IDLE;
		if (i_pa_request)
			grant = BUSY_A;
		else if (i_pb_request)
			grant = BUSY_B;
		else if (i_pc_request)
			grant = BUSY_C;
	end

	//==========================================================================
	// Grant FSM
	//==========================================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			bus_request <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					state <= grant;
					bus_request <= (grant != IDLE);
				end
				BUSY_A, BUSY_B, BUSY_C: begin
					if (bus.ready) begin
						state <= RELEASE;
						bus_request <= 1'b0;
					end
				end
				// One dead cycle so a request dropped on ready is not reissued
				default: state <= IDLE;
			endcase
		end
	end

	// Payload latched with the grant
	always_ff @(posedge i_clock) begin
		if (state == IDLE) begin
			case (grant)
				BUSY_A: begin
					bus_rw <= 1'b0;
					bus_address <= i_pa_address;
					bus_wdata <= '0;
				end
				BUSY_B: begin
					bus_rw <= i_pb_rw;
					bus_address <= i_pb_address;
					bus_wdata <= i_pb_wdata;
				end
				BUSY_C: begin
					bus_rw <= i_pc_rw;
					bus_address <= i_pc_address;
					bus_wdata <= i_pc_wdata;
				end
				default: ;
			endcase
		end
	end

	assign bus.request = bus_request;
	assign bus.rw      = bus_rw;
	assign bus.address = bus_address;
	assign bus.wdata   = bus_wdata;

	// Response goes back to the granted port only
	assign o_pa_ready = (state == BUSY_A) && bus.ready;
	assign o_pb_ready = (state == BUSY_B) && bus.ready;
	assign o_pc_ready = (state == BUSY_C) && bus.ready;

	assign o_pa_rdata = (state == BUSY_A) ? bus.rdata : '0;
	assign o_pb_rdata = (state == BUSY_B) ? bus.rdata : '0;
	assign o_pc_rdata = (state == BUSY_C) ? bus.rdata : '0;

endmodule

// File: soc_bus_if.sv
//==========================================================================
// One bus link with master and slave views
//==========================================================================

`timescale 1ns/1ps
`include "soc_macros.svh"

interface soc_bus_if;

	// Request side, held by the master until ready
	logic                   request;
	logic                   rw;
	logic [`SOC_ADDR_W-1:0] address;
	logic [`SOC_DATA_W-1:0] wdata;

	// Response side, valid for the single ready cycle
	logic [`SOC_DATA_W-1:0] rdata;
	logic                   ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

// File: soc_pkg.sv
//==========================================================================
// Shared types: arbiter state, system region and far device
//==========================================================================

package soc_pkg;

	// Arbiter grant state
	typedef enum logic [2:0] {
		IDLE,
		BUSY_A,
		BUSY_B,
		BUSY_C,
		RELEASE
	} arb_state_t;

	// Decoded system region, from address bits 31:28
	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_BRIDGE,
		REGION_NONE
	} region_t;

	// Decoded device behind the bridge, from address bits 27:24
	typedef enum logic [1:0] {
		DEV_LED,
		DEV_TIMER,
		DEV_NONE
	} far_device_t;

endpackage

// File: soc_macros.svh
//==========================================================================
// Bus widths, address map codes, RAM depth and timer register offsets
//==========================================================================

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 32

// System regions on address bits 31:28
`define SOC_REGION_RAM    4'h1
`define SOC_REGION_BRIDGE 4'h5

// Far devices on address bits 27:24
`define SOC_DEV_LED   4'h0
`define SOC_DEV_TIMER 4'h5

// Block RAM depth in words
`define SOC_RAM_WORDS 512

`define SOC_LED_W 10

// Timer registers, byte offsets within the device
`define SOC_TIMER_OFS_COUNT   4'h0
`define SOC_TIMER_OFS_COMPARE 4'h4

`endif
